/* sources.f */
design/engine_pkg.sv
design/apb_map_pkg.sv
design/rv_regfile.sv
design/vec_alu.sv
design/elem_counter.sv
design/seq_fsm.sv
design/apb_regs.sv
design/vec_engine_top.sv
sim/tb_vec_engine.sv

/* Makefile */
# Verilator build and run of the vector engine testbench

VERILATOR ?= verilator
TOP       ?= tb_vec_engine
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Result: PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* sim/tb_vec_engine.sv */
// Directed testbench for the vector engine that drives the APB slave and checks a register model
`timescale 1ns/10ps

module tb_vec_engine import engine_pkg::*; import apb_map_pkg::*; ();

  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned SEED       = 32'had4d6684;

  // Cycle budget of each test
  // Watchdog allows twice their sum
  localparam int BUDGET_RESET  = 10;
  localparam int BUDGET_WINDOW = 300;
  localparam int BUDGET_OPS    = 1200;
  localparam int BUDGET_WRAP   = 400;
  localparam int BUDGET_ERRORS = 500;
  localparam int BUDGET_CLEAR  = 300;
  localparam int WATCHDOG_NS   = 2 * 4 * (BUDGET_RESET + BUDGET_WINDOW + BUDGET_OPS +
                                          BUDGET_WRAP + BUDGET_ERRORS + BUDGET_CLEAR);

  logic                  clk_i;
  logic                  rst_ni;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [DATA_WIDTH-1:0] pwdata;
  logic [DATA_WIDTH-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  // Expected contents of the register file
  logic [31:0] model [32];

  vec_engine_top #(
    .DATA_WIDTH (DATA_WIDTH)
  ) DUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  // Element result as the operation encoding defines it
  function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      int'(OP_ADD): return a + b;
      int'(OP_SUB): return a - b;
      int'(OP_AND): return a & b;
      int'(OP_OR):  return a | b;
      int'(OP_XOR): return a ^ b;
      int'(OP_SLL): return a << b[4:0];
      default:      return '0;
    endcase
  endfunction

  function automatic logic [31:0] cmd_word(input int rd, input int rs1, input int rs2,
                                           input int op, input int len);
    logic [31:0] w;
    w = '0;
    w[CMD_RD_LSB +: REG_ADDR_W]  = REG_ADDR_W'(rd);
    w[CMD_RS1_LSB +: REG_ADDR_W] = REG_ADDR_W'(rs1);
    w[CMD_RS2_LSB +: REG_ADDR_W] = REG_ADDR_W'(rs2);
    w[CMD_OP_LSB +: 3]           = 3'(op);
    w[CMD_LEN_LSB +: LEN_W]      = LEN_W'(len);
    return w;
  endfunction

  function automatic logic [APB_ADDR_W-1:0] win_addr(input int n);
    return REG_WIN_BASE + APB_ADDR_W'(4 * n);
  endfunction

  // One APB transfer through setup and access phases
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waits;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk_i);
    #1;
    penable = 1'b1;
    waits   = 0;
    // Sample pready mid-cycle where it is stable
    @(negedge clk_i);
    while (!pready && waits < 4) begin
      @(negedge clk_i);
      waits++;
    end
    if (!pready) begin
      abort_run("APB slave never raised pready");
    end
    if (waits != 1) begin
      abort_run("APB slave did not insert exactly one wait state");
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk_i);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused_rdata;
    apb_xfer(1'b1, addr, data, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic write_expect(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                              input logic exp_err, input string name);
    logic err;
    apb_write(addr, data, err);
    check_eq(name, {31'd0, exp_err}, {31'd0, err});
  endtask

  task automatic read_expect(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp,
                             input string name);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_eq({name, " pslverr"}, 32'd0, {31'd0, err});
    check_eq(name, exp, data);
  endtask

  // Register 0 ignores writes
  task automatic write_reg(input int n, input logic [31:0] val);
    write_expect(win_addr(n), val, 1'b0, $sformatf("window write r%0d", n));
    if (n != 0) begin
      model[n] = val;
    end
  endtask

  task automatic fill_range(input int base, input int len);
    for (int i = 0; i < len; i++) begin
      write_reg((base + i) % 32, $urandom());
    end
  endtask

  task automatic check_all_regs(input string name);
    for (int n = 0; n < 32; n++) begin
      read_expect(win_addr(n), model[n], $sformatf("%s r%0d", name, n));
    end
  endtask

  // Loads CMD, updates the model from a snapshot and issues go
  task automatic run_cmd(input int rd, input int rs1, input int rs2, input int op,
                         input int len);
    logic [31:0] old [32];
    int          d;
    old = model;
    write_expect(OFF_CMD, cmd_word(rd, rs1, rs2, op, len), 1'b0, "cmd write");
    for (int i = 0; i < len; i++) begin
      d = (rd + i) % 32;
      if (d != 0) begin
        model[d] = alu_ref(op, old[(rs1 + i) % 32], old[(rs2 + i) % 32]);
      end
    end
    write_expect(OFF_CTRL, 32'h1, 1'b0, "go write");
  endtask

  // Poll STATUS until the sticky done bit shows up
  task automatic wait_done();
    logic [31:0] data;
    logic        err;
    int          polls;
    data  = '0;
    polls = 0;
    while (!data[1] && polls < 100) begin
      apb_read(OFF_STATUS, data, err);
      polls++;
    end
    if (!data[1]) begin
      abort_run("engine never reported done");
    end
    check_eq("status after done", 32'h2, data);
  endtask

  task automatic access_window();
    read_expect(OFF_CMD, 32'd0, "window cmd after reset");
    read_expect(win_addr(7), 32'd0, "window reg after reset");
    for (int n = 1; n < 32; n++) begin
      write_reg(n, $urandom());
    end
    write_reg(0, 32'hdeadbeef);
    check_all_regs("window");
  endtask

  // Three disjoint ranges of 8 that sometimes wrap past 31
  task automatic run_every_op();
    int base;
    for (int k = 0; k < 6; k++) begin
      base = (24 + 3 * k) % 32;
      fill_range(base, 8);
      fill_range((base + 8) % 32, 8);
      run_cmd((base + 16) % 32, base, (base + 8) % 32, k, 8);
      wait_done();
      check_all_regs($sformatf("op %0d", k));
    end
  endtask

  // Length 32 covers the whole file, so rd sits at or one above each
  // source base and every element is read before it gets overwritten
  task automatic run_full_wrap();
    fill_range(0, 32);
    run_cmd(31, 30, 31, int'(OP_SUB), 32);
    wait_done();
    check_all_regs("wrap");
  endtask

  task automatic provoke_errors();
    logic [31:0] data;
    logic        err;
    run_cmd(0, 0, 0, int'(OP_ADD), 32);
    read_expect(OFF_STATUS, 32'h1, "errors busy");
    write_expect(OFF_CTRL, 32'h1, 1'b1, "errors go busy");
    write_expect(OFF_CTRL, 32'h2, 1'b1, "errors clear busy");
    write_expect(win_addr(5), 32'h1234_5678, 1'b1, "errors window busy");
    write_expect(OFF_CMD, cmd_word(3, 4, 5, int'(OP_XOR), 4), 1'b1, "errors cmd busy");
    wait_done();
    read_expect(OFF_CMD, cmd_word(0, 0, 0, int'(OP_ADD), 32), "errors cmd kept");
    write_expect(OFF_CMD, cmd_word(1, 9, 17, 7, 8), 1'b0, "errors op 7 cmd");
    write_expect(OFF_CTRL, 32'h1, 1'b1, "errors op 7 go");
    write_expect(OFF_CMD, cmd_word(1, 9, 17, int'(OP_ADD), 0), 1'b0, "errors len 0 cmd");
    write_expect(OFF_CTRL, 32'h1, 1'b1, "errors len 0 go");
    apb_read(8'h0c, data, err);
    check_eq("errors unmapped", 32'd1, {31'd0, err});
    read_expect(OFF_STATUS, 32'h2, "errors status idle");
    check_all_regs("errors");
  endtask

  task automatic clear_and_rerun();
    logic [31:0] data;
    logic        err;
    read_expect(OFF_STATUS, 32'h2, "clear done before");
    write_expect(OFF_CTRL, 32'h2, 1'b0, "clear write");
    for (int n = 0; n < 32; n++) begin
      model[n] = '0;
    end
    check_all_regs("clear");
    // Fresh sources so the rerun writes visible results
    fill_range(0, 8);
    fill_range(16, 8);
    run_cmd(8, 0, 16, int'(OP_OR), 8);
    apb_read(OFF_STATUS, data, err);
    check_eq("clear done after go", 32'd0, {31'd0, data[1]});
    wait_done();
    check_all_regs("clear rerun");
  endtask

  initial begin
    void'($urandom(SEED));
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int n = 0; n < 32; n++) begin
      model[n] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    access_window();
    run_every_op();
    run_full_wrap();
    provoke_errors();
    clear_and_rerun();
    $display("Result: PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

/* design/vec_engine_top.sv */
// Top level of the vector engine, an APB slave in front of the sequencer, ALU and register file
`timescale 1ns/10ps

module vec_engine_top import engine_pkg::*; import apb_map_pkg::*; #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // APB slave
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [DATA_WIDTH-1:0] pwdata_i,
  output logic [DATA_WIDTH-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  // Control between slave, sequencer and counter
  logic start;
  logic clear;
  logic busy;
  logic done;
  logic load;
  logic step;
  logic valid;
  logic last;

  // Command fields and element index
  logic [REG_ADDR_W-1:0] cmd_rd;
  logic [REG_ADDR_W-1:0] cmd_rs1;
  logic [REG_ADDR_W-1:0] cmd_rs2;
  alu_op_e               cmd_op;
  logic [LEN_W-1:0]      cmd_len;
  logic [REG_ADDR_W-1:0] idx;
  logic [REG_ADDR_W-1:0] elem_rd;

  // Register file ports, read 0 and 1 for operands, read 2 for the window
  logic [2:0][REG_ADDR_W-1:0] raddr;
  logic [2:0][DATA_WIDTH-1:0] rdata;
  logic [1:0][REG_ADDR_W-1:0] waddr;
  logic [1:0][DATA_WIDTH-1:0] wdata;
  logic [1:0]                 we;

  apb_regs #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_apb_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .busy_i      (busy),
    .done_i      (done),
    .start_o     (start),
    .clear_o     (clear),
    .cmd_rd_o    (cmd_rd),
    .cmd_rs1_o   (cmd_rs1),
    .cmd_rs2_o   (cmd_rs2),
    .cmd_op_o    (cmd_op),
    .cmd_len_o   (cmd_len),
    .win_raddr_o (raddr[2]),
    .win_rdata_i (rdata[2]),
    .win_we_o    (we[0]),
    .win_waddr_o (waddr[0]),
    .win_wdata_o (wdata[0])
  );

  seq_fsm i_seq_fsm (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start),
    .last_i  (last),
    .load_o  (load),
    .step_o  (step),
    .valid_o (valid),
    .busy_o  (busy),
    .done_o  (done)
  );

  elem_counter i_elem_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (load),
    .len_i  (cmd_len),
    .step_i (step),
    .idx_o  (idx),
    .last_o (last)
  );

  // Base plus index, wrapping modulo 32 by width
  assign raddr[0] = cmd_rs1 + idx;
  assign raddr[1] = cmd_rs2 + idx;
  assign elem_rd  = cmd_rd + idx;

  vec_alu #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_vec_alu (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (valid),
    .op_i    (cmd_op),
    .a_i     (rdata[0]),
    .b_i     (rdata[1]),
    .rd_i    (elem_rd),
    .we_o    (we[1]),
    .waddr_o (waddr[1]),
    .wdata_o (wdata[1])
  );

  // ALU write-back on port 1 overrides a window write
  rv_regfile #(
    .DATA_WIDTH     (DATA_WIDTH),
    .NR_READ_PORTS  (3),
    .NR_WRITE_PORTS (2)
  ) i_rv_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear),
    .raddr_i (raddr),
    .rdata_o (rdata),
    .waddr_i (waddr),
    .wdata_i (wdata),
    .we_i    (we)
  );

endmodule

/* design/apb_regs.sv */
// APB slave holding the command, status and control pulses of the engine, used by the top level
`timescale 1ns/10ps

module apb_regs import engine_pkg::*; import apb_map_pkg::*; #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // APB slave
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [DATA_WIDTH-1:0] pwdata_i,
  output logic [DATA_WIDTH-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // Sequencer status
  input  logic                  busy_i,
  input  logic                  done_i,
  // Control pulses
  output logic                  start_o,
  output logic                  clear_o,
  // Current command
  output logic [REG_ADDR_W-1:0] cmd_rd_o,
  output logic [REG_ADDR_W-1:0] cmd_rs1_o,
  output logic [REG_ADDR_W-1:0] cmd_rs2_o,
  output alu_op_e               cmd_op_o,
  output logic [LEN_W-1:0]      cmd_len_o,
  // Register window
  output logic [REG_ADDR_W-1:0] win_raddr_o,
  input  logic [DATA_WIDTH-1:0] win_rdata_i,
  output logic                  win_we_o,
  output logic [REG_ADDR_W-1:0] win_waddr_o,
  output logic [DATA_WIDTH-1:0] win_wdata_o
);

  // Transfer state
  logic                  access;
  logic                  wr_ok;
  logic                  err;
  logic                  pready_q;
  logic                  pslverr_q;
  logic [DATA_WIDTH-1:0] prdata_q;
  logic [DATA_WIDTH-1:0] rdata_mux;

  // Address decode
  logic                  hit_ctrl;
  logic                  hit_cmd;
  logic                  hit_status;
  logic                  hit_win;
  logic [APB_ADDR_W-1:0] win_off;

  // CTRL request bits and command legality
  logic                  go_req;
  logic                  clr_req;
  logic                  cmd_legal;

  // Held registers
  logic                  start_q;
  logic                  clear_q;
  logic                  done_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [REG_ADDR_W-1:0] rs1_q;
  logic [REG_ADDR_W-1:0] rs2_q;
  logic [2:0]            op_q;
  logic [LEN_W-1:0]      len_q;

  // First access cycle, pready follows one cycle later as the wait state
  assign access = psel_i && penable_i && !pready_q;

  assign hit_ctrl   = (paddr_i == OFF_CTRL);
  assign hit_cmd    = (paddr_i == OFF_CMD);
  assign hit_status = (paddr_i == OFF_STATUS);
  assign hit_win    = (paddr_i >= REG_WIN_BASE);

  // Word index inside the window
  assign win_off     = paddr_i - REG_WIN_BASE;
  assign win_raddr_o = win_off[REG_ADDR_W+1:2];

  assign go_req    = pwdata_i[CTRL_GO_BIT];
  assign clr_req   = pwdata_i[CTRL_CLEAR_BIT];
  assign cmd_legal = (op_q <= 3'(OP_SLL)) && (len_q != '0);

  // Error rules, all busy and legality checks live here
  always_comb begin
    err = 1'b0;
    if (!(hit_ctrl || hit_cmd || hit_status || hit_win)) begin
      err = 1'b1;
    end else if (pwrite_i) begin
      if (hit_ctrl) begin
        if ((go_req || clr_req) && busy_i) begin
          err = 1'b1;
        end else if (go_req && !cmd_legal) begin
          err = 1'b1;
        end
      end else if ((hit_cmd || hit_win) && busy_i) begin
        err = 1'b1;
      end
    end
  end

  // Only error-free writes have side effects
  assign wr_ok = access && pwrite_i && !err;

  // Read data select, CTRL reads back as zero
  always_comb begin
    rdata_mux = '0;
    if (hit_cmd) begin
      rdata_mux[CMD_RD_LSB +: REG_ADDR_W]  = rd_q;
      rdata_mux[CMD_RS1_LSB +: REG_ADDR_W] = rs1_q;
      rdata_mux[CMD_RS2_LSB +: REG_ADDR_W] = rs2_q;
      rdata_mux[CMD_OP_LSB +: 3]           = op_q;
      rdata_mux[CMD_LEN_LSB +: LEN_W]      = len_q;
    end else if (hit_status) begin
      rdata_mux[STATUS_BUSY_BIT] = busy_i;
      rdata_mux[STATUS_DONE_BIT] = done_q;
    end else if (hit_win) begin
      rdata_mux = win_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      start_q   <= 1'b0;
      clear_q   <= 1'b0;
      done_q    <= 1'b0;
      rd_q      <= '0;
      rs1_q     <= '0;
      rs2_q     <= '0;
      op_q      <= '0;
      len_q     <= '0;
    end else begin
      pready_q  <= access;
      pslverr_q <= access && err;
      start_q   <= wr_ok && hit_ctrl && go_req;
      clear_q   <= wr_ok && hit_ctrl && clr_req;
      // Sticky done, a legal go wipes it
      if (wr_ok && hit_ctrl && go_req) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
      if (wr_ok && hit_cmd) begin
        rd_q  <= pwdata_i[CMD_RD_LSB +: REG_ADDR_W];
        rs1_q <= pwdata_i[CMD_RS1_LSB +: REG_ADDR_W];
        rs2_q <= pwdata_i[CMD_RS2_LSB +: REG_ADDR_W];
        op_q  <= pwdata_i[CMD_OP_LSB +: 3];
        len_q <= pwdata_i[CMD_LEN_LSB +: LEN_W];
      end
    end
  end

  // Read data captured in the first access cycle
  always_ff @(posedge clk_i) begin
    if (access) begin
      prdata_q <= pwrite_i ? '0 : rdata_mux;
    end
  end

  assign prdata_o  = prdata_q;
  assign pready_o  = pready_q;
  assign pslverr_o = pslverr_q;
  assign start_o   = start_q;
  assign clear_o   = clear_q;

  assign cmd_rd_o  = rd_q;
  assign cmd_rs1_o = rs1_q;
  assign cmd_rs2_o = rs2_q;
  assign cmd_op_o  = alu_op_e'(op_q);
  assign cmd_len_o = len_q;

  // Window write goes straight to register file port 0
  assign win_we_o    = wr_ok && hit_win;
  assign win_waddr_o = win_raddr_o;
  assign win_wdata_o = pwdata_i;

endmodule

/* design/seq_fsm.sv */
// Command sequencer FSM that walks the engine through a command, instantiated by the top level
`timescale 1ns/10ps

module seq_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  // One-cycle start from the APB slave
  input  logic start_i,
  // Counter sits on the final element
  input  logic last_i,
  // Counter control
  output logic load_o,
  output logic step_o,
  // Element valid towards the ALU
  output logic valid_o,
  output logic busy_o,
  // One-cycle pulse once the final write has landed
  output logic done_o
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (start_i) state_d = RUN;
      RUN:     if (last_i) state_d = DRAIN;
      // Final element leaves the ALU register during this cycle
      DRAIN:   state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign load_o  = (state_q == IDLE) && start_i;
  // One element issued per RUN cycle
  assign step_o  = (state_q == RUN);
  assign valid_o = (state_q == RUN);
  assign busy_o  = (state_q != IDLE);
  assign done_o  = (state_q == DRAIN);

endmodule

/* design/elem_counter.sv */
// Element index counter of a vector command, driven by the sequencer in the engine top level
`timescale 1ns/10ps

module elem_counter import engine_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Start of a command, latches the length
  input  logic                  load_i,
  input  logic [LEN_W-1:0]      len_i,
  // Advance to the next element
  input  logic                  step_i,
  output logic [REG_ADDR_W-1:0] idx_o,
  output logic                  last_o
);

  logic [REG_ADDR_W-1:0] idx_q;
  logic [LEN_W-1:0]      len_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
      len_q <= '0;
    end else if (load_i) begin
      idx_q <= '0;
      len_q <= len_i;
    end else if (step_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign idx_o = idx_q;

  // Compare at length width so that a length of 32 still matches index 31
  assign last_o = (LEN_W'(idx_q) == len_q - 1'b1);

endmodule

/* design/vec_alu.sv */
// Element ALU with one register stage on the write-back side, used by the engine top level
`timescale 1ns/10ps

module vec_alu import engine_pkg::*; #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Element operands, valid for one cycle
  input  logic                  valid_i,
  input  alu_op_e               op_i,
  input  logic [DATA_WIDTH-1:0] a_i,
  input  logic [DATA_WIDTH-1:0] b_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  // Registered write-back towards the register file
  output logic                  we_o,
  output logic [REG_ADDR_W-1:0] waddr_o,
  output logic [DATA_WIDTH-1:0] wdata_o
);

  logic [DATA_WIDTH-1:0] result;

  // Operation select, illegal codes never reach here
  always_comb begin
    unique case (op_i)
      OP_ADD:  result = a_i + b_i;
      OP_SUB:  result = a_i - b_i;
      OP_AND:  result = a_i & b_i;
      OP_OR:   result = a_i | b_i;
      OP_XOR:  result = a_i ^ b_i;
      OP_SLL:  result = a_i << b_i[SHAMT_W-1:0];
      default: result = '0;
    endcase
  end

  // Write enable carries control reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_o <= 1'b0;
    end else begin
      we_o <= valid_i;
    end
  end

  // Result and destination follow the enable one cycle later
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      waddr_o <= rd_i;
      wdata_o <= result;
    end
  end

endmodule

/* design/rv_regfile.sv */
// Flip-flop register file with several read and write ports, instantiated by the engine top level
`timescale 1ns/10ps

module rv_regfile import engine_pkg::*; #(
  parameter int unsigned DATA_WIDTH     = 32,
  parameter int unsigned NR_READ_PORTS  = 3,
  parameter int unsigned NR_WRITE_PORTS = 2
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Synchronous clear of the whole file
  input  logic                                      clear_i,
  // Combinational read ports
  input  logic [NR_READ_PORTS-1:0][REG_ADDR_W-1:0]  raddr_i,
  output logic [NR_READ_PORTS-1:0][DATA_WIDTH-1:0]  rdata_o,
  // Write ports, higher index wins a conflict
  input  logic [NR_WRITE_PORTS-1:0][REG_ADDR_W-1:0] waddr_i,
  input  logic [NR_WRITE_PORTS-1:0][DATA_WIDTH-1:0] wdata_i,
  input  logic [NR_WRITE_PORTS-1:0]                 we_i
);

  // Storage array
  logic [NUM_REGS-1:0][DATA_WIDTH-1:0] regs_q;

  // One-hot write enable per port and register
  logic [NR_WRITE_PORTS-1:0][NUM_REGS-1:0] we_dec;

  // Address decode of every write port
  always_comb begin
    for (int unsigned p = 0; p < NR_WRITE_PORTS; p++) begin
      for (int unsigned r = 0; r < NUM_REGS; r++) begin
        we_dec[p][r] = we_i[p] && (waddr_i[p] == REG_ADDR_W'(r));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (clear_i) begin
      regs_q <= '0;
    end else begin
      // Later port assignments override earlier ones
      for (int unsigned p = 0; p < NR_WRITE_PORTS; p++) begin
        for (int unsigned r = 0; r < NUM_REGS; r++) begin
          if (we_dec[p][r]) begin
            regs_q[r] <= wdata_i[p];
          end
        end
      end
      // Register 0 is hardwired to zero
      regs_q[0] <= '0;
    end
  end

  // Read muxes
  for (genvar i = 0; i < NR_READ_PORTS; i++) begin : g_read
    assign rdata_o[i] = regs_q[raddr_i[i]];
  end

endmodule

/* design/apb_map_pkg.sv */
// APB address map and CMD field positions, imported by the APB slave and the top level
package apb_map_pkg;

  // Byte address width on the bus
  localparam int unsigned APB_ADDR_W = 8;

  // Control registers in the low half of the map
  localparam logic [APB_ADDR_W-1:0] OFF_CTRL   = 8'h00;
  localparam logic [APB_ADDR_W-1:0] OFF_CMD    = 8'h04;
  localparam logic [APB_ADDR_W-1:0] OFF_STATUS = 8'h08;

  // Register file window, register n at base plus 4n
  localparam logic [APB_ADDR_W-1:0] REG_WIN_BASE = 8'h80;

  // CTRL pulse bits, write only
  localparam int unsigned CTRL_GO_BIT    = 0;
  localparam int unsigned CTRL_CLEAR_BIT = 1;

  // STATUS bits
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  // CMD field positions
  localparam int unsigned CMD_RD_LSB  = 0;
  localparam int unsigned CMD_RS1_LSB = 5;
  localparam int unsigned CMD_RS2_LSB = 10;
  localparam int unsigned CMD_OP_LSB  = 15;
  localparam int unsigned CMD_LEN_LSB = 18;

endpackage

/* design/engine_pkg.sv */
// Register-file geometry and ALU operation codes, imported by the datapath and sequencer blocks
package engine_pkg;

  // Register index width and register count
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W;

  // Command length field width
  // Length 0 is illegal, 1 to 32 are meaningful
  localparam int unsigned LEN_W = 6;

  // Shift amount for OP_SLL, taken from the low bits of operand b
  localparam int unsigned SHAMT_W = 5;

  // Element operation encoding
  // Codes 6 and 7 are illegal and get refused at go time
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5
  } alu_op_e;

endpackage
